/* hdl/cam_pkg.sv */
// ------------------------------------------------------------------------
// Camera capture definitions
// Frame geometry, sensor and pixel types, capture FSM states
// ------------------------------------------------------------------------
package cam_pkg;

    // Fixed frame size, small enough for on-chip storage
    localparam int FRAME_LINES   = 4;
    localparam int FRAME_COLUMNS = 8;
    localparam int FRAME_PIXELS  = FRAME_LINES * FRAME_COLUMNS;

    // One byte from the sensor parallel bus
    typedef logic [7:0]  cam_byte_t;
    // RGB565, high byte arrives first
    typedef logic [15:0] pixel_t;

    // Counters sized to the frame geometry
    typedef logic [1:0]  line_idx_t;
    typedef logic [2:0]  col_idx_t;
    // Line index in the upper bits, column in the lower bits
    typedef logic [4:0]  pix_addr_t;
    typedef logic [7:0]  frame_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_FRAME,
        FIRST_BYTE,
        SECOND_BYTE,
        DONE
    } capture_state_t;

endpackage

/* hdl/apb_pkg.sv */
// ------------------------------------------------------------------------
// APB register map of the camera capture block
// ------------------------------------------------------------------------
package apb_pkg;

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Register offsets
    localparam apb_addr_t REG_CTRL     = 4'h0;
    localparam apb_addr_t REG_STATUS   = 4'h4;
    localparam apb_addr_t REG_PIX_ADDR = 4'h8;
    localparam apb_addr_t REG_PIX_DATA = 4'hC;

    // Writing 1 here starts a capture
    localparam int CTRL_START_BIT = 0;

    // Status register fields
    localparam int STATUS_BUSY_BIT   = 0;
    localparam int STATUS_DONE_BIT   = 1;
    localparam int STATUS_FRAMES_LSB = 8;

endpackage

/* hdl/frame_buffer.sv */
// ------------------------------------------------------------------------
// Frame buffer
// One frame of RGB565 pixels, write port and registered read port
// ------------------------------------------------------------------------
module frame_buffer
    import cam_pkg::*;
(
    input  logic      clock,
    input  logic      wr_en,
    input  pix_addr_t wr_addr,
    input  pixel_t    wr_pixel,
    input  pix_addr_t rd_addr,
    output pixel_t    rd_pixel
);

    // Depth matches one full frame
    pixel_t mem [FRAME_PIXELS];

    // Capture side writes, one pixel per enable
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    // Host side read
    // Data valid one cycle after the address
    always_ff @(posedge clock) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

/* hdl/ov7670_capture_ctrl.sv */
// ------------------------------------------------------------------------
// OV7670 capture control unit
// Waits for frame start, pairs bytes and writes pixels for one frame
// ------------------------------------------------------------------------
module ov7670_capture_ctrl
    import cam_pkg::*;
(
    input  logic clock,
    input  logic rst_n,
    input  logic start,
    input  logic vsync_fall,
    input  logic vsync_rise,
    input  logic byte_valid,
    input  logic last_pixel,
    output logic busy,
    output logic frame_done,
    output logic clear_counters,
    output logic capture_en,
    output logic pix_we
);

    capture_state_t state;
    capture_state_t state_next;
    // Low byte latched and write goes out next cycle
    logic pair_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            pair_ready <= 1'b0;
        end else begin
            state      <= state_next;
            pair_ready <= (state == SECOND_BYTE) && byte_valid && !pair_ready && !vsync_rise;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:        if (start) state_next = WAIT_FRAME;
            // Frame starts on VSYNC falling
            WAIT_FRAME:  if (vsync_fall) state_next = FIRST_BYTE;
            FIRST_BYTE: begin
                if (vsync_rise) state_next = DONE;
                else if (byte_valid) state_next = SECOND_BYTE;
            end
            SECOND_BYTE: begin
                // Write cycle takes priority over end of frame
                if (pair_ready) state_next = last_pixel ? DONE : FIRST_BYTE;
                else if (vsync_rise) state_next = DONE;
            end
            DONE:        state_next = IDLE;
            default:     state_next = IDLE;
        endcase
    end

    assign busy           = (state != IDLE);
    assign frame_done     = (state == DONE);
    assign clear_counters = (state == WAIT_FRAME) && vsync_fall;
    assign capture_en     = (state == FIRST_BYTE) || (state == SECOND_BYTE);
    assign pix_we         = (state == SECOND_BYTE) && pair_ready;

    // PCLK at most a quarter of clock keeps bytes out of the write cycle
    a_no_byte_on_write: assert property (@(posedge clock) disable iff (!rst_n)
        pix_we |-> !byte_valid);

endmodule

/* hdl/ov7670_capture_dp.sv */
// ------------------------------------------------------------------------
// OV7670 capture datapath
// Input synchronizers, byte pairing, write addressing and XCLK divider
// ------------------------------------------------------------------------
module ov7670_capture_dp
    import cam_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      VSYNC,
    input  logic      HREF,
    input  logic      PCLK,
    input  cam_byte_t D,
    input  logic      clear_counters,
    input  logic      capture_en,
    input  logic      pix_we,
    output logic      vsync_fall,
    output logic      vsync_rise,
    output logic      byte_valid,
    output logic      last_pixel,
    output logic      XCLK,
    output pix_addr_t wr_addr,
    output pixel_t    wr_pixel
);

    // Two-flop synchronizers, bit 1 is the stable stage
    logic [1:0] vsync_sync;
    logic [1:0] href_sync;
    logic [1:0] pclk_sync;
    // Previous stable values for edge detection
    logic       vsync_prev;
    logic       pclk_prev;
    cam_byte_t  d_s1;
    cam_byte_t  d_s2;
    cam_byte_t  hi_byte;
    cam_byte_t  lo_byte;
    // 0 while the next byte is the high byte
    logic       byte_sel;
    line_idx_t  line_cnt;
    col_idx_t   col_cnt;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            vsync_sync <= '0;
            href_sync  <= '0;
            pclk_sync  <= '0;
            vsync_prev <= 1'b0;
            pclk_prev  <= 1'b0;
            XCLK       <= 1'b0;
        end else begin
            vsync_sync <= {vsync_sync[0], VSYNC};
            href_sync  <= {href_sync[0], HREF};
            pclk_sync  <= {pclk_sync[0], PCLK};
            vsync_prev <= vsync_sync[1];
            pclk_prev  <= pclk_sync[1];
            // Sensor clock at half the system clock
            XCLK       <= ~XCLK;
        end
    end

    assign vsync_fall = vsync_prev & ~vsync_sync[1];
    assign vsync_rise = ~vsync_prev & vsync_sync[1];
    // PCLK rise inside an active line
    assign byte_valid = pclk_sync[1] & ~pclk_prev & href_sync[1];

    // Data bus follows the same two-stage delay as PCLK
    always_ff @(posedge clock) begin
        d_s1 <= D;
        d_s2 <= d_s1;
        if (capture_en && byte_valid) begin
            if (!byte_sel) hi_byte <= d_s2;
            else lo_byte <= d_s2;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            byte_sel <= 1'b0;
            line_cnt <= '0;
            col_cnt  <= '0;
        end else if (clear_counters) begin
            byte_sel <= 1'b0;
            line_cnt <= '0;
            col_cnt  <= '0;
        end else begin
            if (capture_en && byte_valid) byte_sel <= ~byte_sel;
            // Advance address after each pixel write
            if (pix_we) begin
                if (col_cnt == col_idx_t'(FRAME_COLUMNS - 1)) begin
                    col_cnt  <= '0;
                    line_cnt <= line_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // Power-of-two line length, so line and column just concatenate
    assign wr_addr    = {line_cnt, col_cnt};
    assign wr_pixel   = {hi_byte, lo_byte};
    assign last_pixel = (wr_addr == pix_addr_t'(FRAME_PIXELS - 1));

endmodule

/* hdl/apb_cam_regs.sv */
// ------------------------------------------------------------------------
// APB register slave for the camera capture block
// Control, status, pixel read pointer and auto-increment data window
// ------------------------------------------------------------------------
module apb_cam_regs
    import apb_pkg::*;
    import cam_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      start,
    input  logic      busy,
    input  logic      frame_done,
    output pix_addr_t rd_addr,
    input  pixel_t    rd_pixel
);

    logic       access;
    logic       mapped;
    logic       pix_rd;
    logic       complete;
    logic       start_req;
    // High in the second access cycle of a pixel read
    logic       pix_wait;
    logic       done_bit;
    frame_cnt_t frame_cnt;
    pix_addr_t  rd_ptr;
    apb_data_t  status;

    assign access    = psel && penable;
    assign mapped    = (paddr == REG_CTRL) || (paddr == REG_STATUS) ||
                       (paddr == REG_PIX_ADDR) || (paddr == REG_PIX_DATA);
    assign pix_rd    = access && !pwrite && (paddr == REG_PIX_DATA);
    // Pixel reads wait one cycle for the buffer
    assign pready    = access && (!pix_rd || pix_wait);
    assign complete  = access && pready;
    assign start_req = pwrite && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
    // Error on unmapped address or start while busy
    assign pslverr   = complete && (!mapped || (start_req && busy));
    assign start     = complete && start_req && !busy;
    assign rd_addr   = rd_ptr;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pix_wait  <= 1'b0;
            done_bit  <= 1'b0;
            frame_cnt <= '0;
            rd_ptr    <= '0;
        end else begin
            pix_wait <= pix_rd && !pix_wait;
            // Sticky done bit cleared by a new capture
            if (start) done_bit <= 1'b0;
            else if (frame_done) done_bit <= 1'b1;
            if (frame_done) frame_cnt <= frame_cnt + 1'b1;
            // Pointer wraps modulo the frame size
            if (complete && pwrite && (paddr == REG_PIX_ADDR)) rd_ptr <= pix_addr_t'(pwdata);
            else if (complete && pix_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_comb begin
        status = '0;
        status[STATUS_BUSY_BIT] = busy;
        status[STATUS_DONE_BIT] = done_bit;
        status[STATUS_FRAMES_LSB +: $bits(frame_cnt_t)] = frame_cnt;
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_STATUS:   prdata = status;
                REG_PIX_ADDR: prdata = apb_data_t'(rd_ptr);
                REG_PIX_DATA: prdata = apb_data_t'(rd_pixel);
                default:      prdata = '0;
            endcase
        end
    end

    // Master holds address and direction through the pixel wait cycle
    a_wait_hold: assert property (@(posedge clock) disable iff (!rst_n)
        access && !pready |=> access && $stable(paddr) && $stable(pwrite));
    // Capture unit goes busy right after a start
    a_start_busy: assert property (@(posedge clock) disable iff (!rst_n)
        start |=> busy);

endmodule

/* hdl/ov7670_interface.sv */
// ------------------------------------------------------------------------
// OV7670 capture block with APB host interface
// ------------------------------------------------------------------------
module ov7670_interface
    import apb_pkg::*;
    import cam_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    input  logic      VSYNC,
    input  logic      HREF,
    input  logic      PCLK,
    input  cam_byte_t D,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      XCLK
);

    // Host to capture control
    logic      start;
    logic      busy;
    logic      frame_done;
    // Control unit to datapath
    logic      clear_counters;
    logic      capture_en;
    logic      pix_we;
    // Synchronized sensor events
    logic      vsync_fall;
    logic      vsync_rise;
    logic      byte_valid;
    logic      last_pixel;
    // Buffer ports
    pix_addr_t wr_addr;
    pixel_t    wr_pixel;
    pix_addr_t rd_addr;
    pixel_t    rd_pixel;

    apb_cam_regs u_regs (
        .clock(clock), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .start(start), .busy(busy), .frame_done(frame_done),
        .rd_addr(rd_addr), .rd_pixel(rd_pixel)
    );

    ov7670_capture_ctrl u_ctrl (
        .clock(clock), .rst_n(rst_n), .start(start), .vsync_fall(vsync_fall),
        .vsync_rise(vsync_rise), .byte_valid(byte_valid), .last_pixel(last_pixel),
        .busy(busy), .frame_done(frame_done), .clear_counters(clear_counters),
        .capture_en(capture_en), .pix_we(pix_we)
    );

    ov7670_capture_dp u_dp (
        .clock(clock), .rst_n(rst_n), .VSYNC(VSYNC), .HREF(HREF), .PCLK(PCLK), .D(D),
        .clear_counters(clear_counters), .capture_en(capture_en), .pix_we(pix_we),
        .vsync_fall(vsync_fall), .vsync_rise(vsync_rise), .byte_valid(byte_valid),
        .last_pixel(last_pixel), .XCLK(XCLK), .wr_addr(wr_addr), .wr_pixel(wr_pixel)
    );

    frame_buffer u_buffer (
        .clock(clock), .wr_en(pix_we), .wr_addr(wr_addr), .wr_pixel(wr_pixel),
        .rd_addr(rd_addr), .rd_pixel(rd_pixel)
    );

endmodule

/* bench/tb_ov7670_interface.sv */
// ------------------------------------------------------------------------
// Testbench for the OV7670 capture block
// Sensor model, APB host, readback checks and watchdog
// ------------------------------------------------------------------------
module tb_ov7670_interface
    import apb_pkg::*;
    import cam_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF_NS   = 10;
    localparam int PCLK_HALF     = 4;
    localparam int LINE_GAP      = 16;
    localparam int VSYNC_GAP     = 16;
    localparam int APB_MAX_WAITS = 8;
    localparam int WRAP_START    = 30;
    localparam logic [31:0] RAND_SEED = 32'h6924_f4c9;
    // Clock cycles of one frame from the sensor model
    localparam int LINE_CYCLES   = FRAME_COLUMNS * 4 * PCLK_HALF + PCLK_HALF + LINE_GAP;
    localparam int FRAME_CYCLES  = FRAME_LINES * LINE_CYCLES + 2 * VSYNC_GAP;
    // File frame, junk frame with junk line, random frame
    localparam int NUM_FRAMES    = 3;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES * NUM_FRAMES + 3000;

    logic      clock;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    logic      VSYNC;
    logic      HREF;
    logic      PCLK;
    cam_byte_t D;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      XCLK;

    // Header word followed by the file pixels
    logic [15:0] file_words [0:FRAME_PIXELS];
    // Pixels the sensor model sends and the expected buffer contents
    pixel_t      frame_pixels [FRAME_PIXELS];

    ov7670_interface UUT (
        .clock(clock), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .VSYNC(VSYNC), .HREF(HREF), .PCLK(PCLK),
        .D(D), .prdata(prdata), .pready(pready), .pslverr(pslverr), .XCLK(XCLK)
    );

    initial begin
        clock = 1'b0;
        forever #CLK_HALF_NS clock = ~clock;
    end

    task automatic fail_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Verification failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            fail_run($sformatf("wrong value on %s", name));
        end
    endtask

    // One APB transfer with outputs sampled 1 ns after the falling edge
    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, output apb_data_t rdata,
                                output logic err);
        int waits;
        int exp_waits;
        waits = 0;
        // Only a pixel data read inserts a wait cycle
        exp_waits = (!write && addr == REG_PIX_DATA) ? 1 : 0;
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        #1;
        while (!pready) begin
            waits++;
            if (waits > APB_MAX_WAITS) fail_run("APB transfer never raised pready");
            @(negedge clock);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        check_value("pready wait cycles", 32'(waits), 32'(exp_waits));
        // Transfer completes at the next rising edge
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        logic      err;
        apb_transfer(1'b1, addr, data, unused, err);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_done,
                                input int exp_frames);
        apb_data_t status;
        read_reg(REG_STATUS, status);
        check_value("status.busy", 32'(status[STATUS_BUSY_BIT]), 32'(exp_busy));
        check_value("status.done", 32'(status[STATUS_DONE_BIT]), 32'(exp_done));
        check_value("status.frames", 32'(status[STATUS_FRAMES_LSB +: $bits(frame_cnt_t)]),
                    32'(exp_frames));
    endtask

    // Poll until the sticky done bit shows up
    task automatic wait_for_done();
        apb_data_t status;
        int        polls;
        polls = 0;
        status = '0;
        while (!status[STATUS_DONE_BIT]) begin
            polls++;
            if (polls > FRAME_CYCLES) fail_run("capture never reported done");
            read_reg(REG_STATUS, status);
        end
    endtask

    // Read the whole buffer from pointer 0 and compare with frame_pixels
    task automatic read_frame();
        apb_data_t data;
        write_reg(REG_PIX_ADDR, '0);
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            read_reg(REG_PIX_DATA, data);
            check_value($sformatf("prdata pixel %0d", i), data, 32'(frame_pixels[i]));
        end
    endtask

    // Sensor byte with PCLK low then high for PCLK_HALF cycles each
    task automatic send_byte(input cam_byte_t value);
        D    = value;
        PCLK = 1'b0;
        repeat (PCLK_HALF) @(negedge clock);
        PCLK = 1'b1;
        repeat (PCLK_HALF) @(negedge clock);
    endtask

    task automatic send_line(input int line, input logic junk);
        pixel_t pix;
        HREF = 1'b1;
        for (int col = 0; col < FRAME_COLUMNS; col++) begin
            if (junk) pix = pixel_t'($urandom);
            else pix = frame_pixels[line * FRAME_COLUMNS + col];
            // High byte first
            send_byte(pix[15:8]);
            send_byte(pix[7:0]);
        end
        PCLK = 1'b0;
        repeat (PCLK_HALF) @(negedge clock);
        HREF = 1'b0;
        repeat (LINE_GAP) @(negedge clock);
    endtask

    task automatic send_frame(input logic junk);
        @(negedge clock);
        // Frame start
        VSYNC = 1'b0;
        repeat (VSYNC_GAP) @(negedge clock);
        for (int line = 0; line < FRAME_LINES; line++) begin
            send_line(line, junk);
        end
        VSYNC = 1'b1;
        repeat (VSYNC_GAP) @(negedge clock);
    endtask

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        fail_run("watchdog expired before the tests finished");
    end

    // XCLK runs at half the system clock once reset is released
    initial begin : xclk_monitor
        logic xclk_last;
        wait (rst_n === 1'b1);
        xclk_last = XCLK;
        forever begin
            @(negedge clock);
            check_value("XCLK", 32'(XCLK), 32'(!xclk_last));
            xclk_last = XCLK;
        end
    end

    initial begin : stimulus
        apb_data_t data;
        logic      err;
        void'($urandom(RAND_SEED));
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        VSYNC   = 1'b1;
        HREF    = 1'b0;
        PCLK    = 1'b0;
        D       = '0;

        $readmemh("bench/testdata_frame.hex", file_words);
        check_value("header pixel count", 32'(file_words[0]), 32'(FRAME_PIXELS));
        for (int i = 0; i < FRAME_PIXELS; i++) frame_pixels[i] = file_words[i + 1];

        repeat (5) @(negedge clock);
        check_value("XCLK in reset", 32'(XCLK), 32'd0);
        rst_n = 1'b1;

        // Idle after reset
        check_status(1'b0, 1'b0, 0);

        // Capture of the file frame
        write_reg(REG_CTRL, apb_data_t'(1));
        check_status(1'b1, 1'b0, 0);
        fork
            send_frame(1'b0);
            begin
                // Second start while the first capture runs
                apb_transfer(1'b1, REG_CTRL, apb_data_t'(1), data, err);
                check_value("pslverr on start while busy", 32'(err), 32'd1);
            end
        join
        wait_for_done();
        check_status(1'b0, 1'b1, 1);
        read_frame();

        // Pointer wraps past the last pixel
        write_reg(REG_PIX_ADDR, apb_data_t'(WRAP_START));
        for (int k = 0; k < 3; k++) begin
            read_reg(REG_PIX_DATA, data);
            check_value("prdata after wrap", data,
                        32'(frame_pixels[(WRAP_START + k) % FRAME_PIXELS]));
        end

        // Unmapped addresses
        apb_transfer(1'b0, apb_addr_t'(4'h2), '0, data, err);
        check_value("pslverr on unmapped read", 32'(err), 32'd1);
        apb_transfer(1'b1, apb_addr_t'(4'h6), apb_data_t'(1), data, err);
        check_value("pslverr on unmapped write", 32'(err), 32'd1);

        // Random frame with junk before start and before VSYNC falls
        for (int i = 0; i < FRAME_PIXELS; i++) frame_pixels[i] = pixel_t'($urandom);
        send_frame(1'b1);
        write_reg(REG_CTRL, apb_data_t'(1));
        send_line(0, 1'b1);
        send_frame(1'b0);
        wait_for_done();
        check_status(1'b0, 1'b1, 2);
        read_frame();

        $display("Verification passed");
        $finish;
    end

endmodule

/* build.f */
hdl/cam_pkg.sv
hdl/apb_pkg.sv
hdl/frame_buffer.sv
hdl/ov7670_capture_ctrl.sv
hdl/ov7670_capture_dp.sv
hdl/apb_cam_regs.sv
hdl/ov7670_interface.sv
bench/tb_ov7670_interface.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the OV7670 capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module tb_ov7670_interface -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

/* bench/testdata_frame.hex */
// First data line: pixel count of the frame
// Then one RGB565 pixel per line, in raster order, high byte sent first
0020
1A03
2B14
3C25
4D36
5E47
6F58
7069
817A
928B
A39C
B4AD
C5BE
D6CF
E7D0
F8E1
09F2
F800
07E0
001F
FFE0
F81F
07FF
8410
C618
0123
4567
89AB
CDEF
FEDC
BA98
7654
3210
